// ==== rtl/rv_isa_pkg.sv ====
// rv32i base encodings only; no compressed, multiply or csr fields are described here
package rv_isa_pkg;

    // architectural widths
    localparam int unsigned xlen    = 32;  // data path width
    localparam int unsigned reg_num = 32;  // x0..x31, x0 hardwired

    typedef logic [4:0]      reg_addr_t;  // register index
    typedef logic [xlen-1:0] word_t;      // register / alu data
    typedef logic [31:0]     instr_t;     // raw instruction word
    typedef logic [4:0]      shamt_t;     // shift amount, low bits of operand b

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_op     = 7'b0110011;  // register-register
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // register-immediate
    localparam logic [6:0] opc_lui    = 7'b0110111;  // load upper immediate

    // funct3, instr[14:12]; shared by op and op-imm
    localparam logic [2:0] f3_add_sub = 3'b000;  // add/sub, addi
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;  // funct7 picks logic or arith
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7, instr[31:25]
    localparam logic [6:0] f7_base = 7'b0000000;  // add, srl and friends
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra

    // field positions, for reference when slicing
    // rd     = instr[11:7]
    // rs1    = instr[19:15]
    // rs2    = instr[24:20]
    // imm_i  = instr[31:20], sign extended
    // imm_u  = instr[31:12], low 12 bits zero
    // shamt  = instr[24:20] on op-imm shifts

endpackage

// ==== rtl/rv_exec_pkg.sv ====
// implementation types of the execute slice; depends on rv_isa_pkg being compiled first
package rv_exec_pkg;

    import rv_isa_pkg::*;

    // alu operation, 4 bits leaves room for more ops
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,   // signed compare
        alu_sltu,  // unsigned compare
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // decoded control for one instruction, valid in the execute cycle
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;  // imm replaces rs2 as operand b
        logic      is_lui;   // imm is the result, alu bypassed
        logic      we;       // legal and strobed
        word_t     imm;      // sign-extended i or u immediate
    } ex_ctrl_t;

    // writeback bundle, also the regfile write port
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef logic [31:0] instret_t;  // retired count, wraps after 2^32

endpackage

// ==== rtl/rv_decoder.sv ====
// pure combinational decode of op, op-imm and lui; every other opcode is reported illegal
module rv_decoder
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic     instr_valid_i,  // one strobe per instruction
    input  instr_t   instr_i,
    output ex_ctrl_t ctrl_o,
    output logic     illegal_o       // valid word we cannot execute
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;  // sign-extended i-type
    word_t      imm_u;  // u-type with low bits zero
    logic       legal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u  = {instr_i[31:12], 12'b0};

    // funct3 to alu op; alt selects sub / sra on the shared encodings
    function automatic alu_op_e f3_to_op(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.rs1     = instr_i[19:15];
        ctrl_o.rs2     = instr_i[24:20];
        ctrl_o.rd      = instr_i[11:7];
        ctrl_o.alu_op  = alu_add;
        ctrl_o.imm     = imm_i;  // shamt sits in imm[4:0] for shifts
        legal          = 1'b0;
        case (opcode)
            opc_op: begin
                ctrl_o.alu_op = f3_to_op(funct3, funct7 == f7_alt);
                // alt only exists for sub and sra
                legal = (funct7 == f7_base) ||
                        ((funct7 == f7_alt) && ((funct3 == f3_add_sub) ||
                                                (funct3 == f3_srl_sra)));
            end
            opc_op_imm: begin
                ctrl_o.use_imm = 1'b1;
                // no subi so alt only matters for srai
                ctrl_o.alu_op  = f3_to_op(funct3,
                                          (funct3 == f3_srl_sra) && (funct7 == f7_alt));
                if (funct3 == f3_sll) begin
                    legal = (funct7 == f7_base);
                end else if (funct3 == f3_srl_sra) begin
                    legal = (funct7 == f7_base) || (funct7 == f7_alt);
                end else begin
                    legal = 1'b1;  // upper bits are immediate
                end
            end
            opc_lui: begin
                ctrl_o.is_lui = 1'b1;
                ctrl_o.imm    = imm_u;
                legal         = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        ctrl_o.we = instr_valid_i && legal;  // rd of x0 still retires
        illegal_o = instr_valid_i && !legal;
    end

endmodule

// ==== rtl/rv_regfile.sv ====
// 2r1w register file whose reset clears all entries; writes land on the clock edge after wb_i
module rv_regfile
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  wb_t       wb_i,      // write port from the writeback stage
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [reg_num];  // entry 0 kept but never written

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;  // x0 writes dropped
        end
    end

    // x0 wins over the pending write, which wins over storage
    function automatic word_t fwd_read(reg_addr_t addr, word_t stored, wb_t wb);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb.valid && (wb.rd == addr)) begin
            data = wb.data;  // same-cycle writeback
        end else begin
            data = stored;
        end
        return data;
    endfunction

    assign rdata1_o = fwd_read(raddr1_i, regs[raddr1_i], wb_i);
    assign rdata2_o = fwd_read(raddr2_i, regs[raddr2_i], wb_i);

    // a valid write must name a known register and carry known data
    a_wb_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wb_i.valid |-> !$isunknown({wb_i.rd, wb_i.data})
    ) else $error("regfile: valid writeback with unknown rd or data");

endmodule

// ==== rtl/rv_alu.sv ====
// combinational rv32i integer alu; shifts take b[4:0], upper bits of b ignored
module rv_alu
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,       // rs1
    input  word_t   b_i,       // rs2 or immediate, muxed outside
    output word_t   result_o
);

    shamt_t shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:  result_o = a_i + b_i;  // wraps, no overflow flag
            alu_sub:  result_o = a_i - b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_slt:  result_o = word_t'($signed(a_i) < $signed(b_i));
            alu_sltu: result_o = word_t'(a_i < b_i);
            alu_xor:  result_o = a_i ^ b_i;
            alu_srl:  result_o = a_i >> shamt;
            alu_sra:  result_o = word_t'($signed(a_i) >>> shamt);  // sign fill
            alu_or:   result_o = a_i | b_i;
            alu_and:  result_o = a_i & b_i;
            default:  result_o = '0;  // unused enum codes
        endcase
    end

endmodule

// ==== rtl/rv_wb_stage.sv ====
// one register stage after execute; no stall input, every cycle is captured
module rv_wb_stage
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ex_ctrl_t ctrl_i,
    input  logic     illegal_i,
    input  word_t    alu_result_i,
    output wb_t      wb_o,
    output logic     illegal_o,    // one-cycle pulse, wb_o.valid low with it
    output instret_t instret_o
);

    word_t wb_data;

    assign wb_data = ctrl_i.is_lui ? ctrl_i.imm : alu_result_i;  // lui skips alu

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o      <= '0;
            illegal_o <= 1'b0;
            instret_o <= '0;
        end else begin
            wb_o.valid <= ctrl_i.we;
            wb_o.rd    <= ctrl_i.rd;
            wb_o.data  <= wb_data;
            illegal_o  <= illegal_i;
            if (ctrl_i.we) begin
                instret_o <= instret_o + 1'b1;  // counts with the writeback edge
            end
        end
    end

    a_no_wrap: assert property (
        @(posedge clk) disable iff (!arst_n_i) wb_o.valid |-> (instret_o != '0)
    ) else $error("wb_stage: retire counter wrapped");

endmodule

// ==== rtl/rv_exec_top.sv ====
// execute slice top; no handshake, so the issuer may strobe an instruction every cycle
module rv_exec_top
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     instr_valid_i,
    input  instr_t   instr_i,
    output wb_t      wb_o,           // also drives the regfile write port
    output logic     illegal_o,
    output instret_t instret_o
);

    ex_ctrl_t ctrl;
    logic     illegal;     // execute-cycle flag, registered in wb stage
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;

    rv_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ctrl_o        (ctrl),
        .illegal_o     (illegal)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_o),      // forwarded to reads in the same cycle
        .raddr1_i (ctrl.rs1),
        .raddr2_i (ctrl.rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (rs1_data),
        .b_i      (ctrl.use_imm ? ctrl.imm : rs2_data),  // operand b select
        .result_o (alu_result)
    );

    rv_wb_stage u_wb_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ctrl_i       (ctrl),
        .illegal_i    (illegal),
        .alu_result_i (alu_result),
        .wb_o         (wb_o),
        .illegal_o    (illegal_o),
        .instret_o    (instret_o)
    );

endmodule

// ==== dv/rv_exec_tb.sv ====
// directed testbench; a register model follows the rv32i rules and results are checked one cycle after issue
module rv_exec_tb
    import rv_isa_pkg::*, rv_exec_pkg::*;
();

    localparam int period         = 8;
    localparam int resp_timeout   = 4;     // cycles allowed for any response
    localparam int watchdog_limit = 5000;  // cycles for the whole run
    localparam int random_count   = 200;

    logic     clk;
    logic     arst_n_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    wb_t      wb_o;
    logic     illegal_o;
    instret_t instret_o;

    word_t    model [32];  // architectural registers with x0 never written
    instret_t exp_count;   // legal instructions since reset
    int       errors;
    int       checks;
    integer   seed;

    rv_exec_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_o          (wb_o),
        .illegal_o     (illegal_o),
        .instret_o     (instret_o)
    );

    always #(period / 2) clk = ~clk;

    // instruction word builders
    function automatic instr_t op_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                       logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic instr_t imm_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                        reg_addr_t rd);
        return {imm, rs1, f3, rd, opc_op_imm};  // shifts pass {funct7, shamt} as imm
    endfunction

    function automatic instr_t lui_word(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, opc_lui};
    endfunction

    // expected result from the model registers
    function automatic word_t predict(instr_t ins);
        word_t a;
        word_t b;
        logic  is_op;
        is_op = (ins[6:0] == opc_op);
        a     = model[ins[19:15]];
        b     = is_op ? model[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        if (ins[6:0] == opc_lui) begin
            return {ins[31:12], 12'h000};
        end
        case (ins[14:12])
            f3_add_sub: return (is_op && ins[30]) ? a - b : a + b;  // bit 30 marks sub
            f3_sll:     return a << b[4:0];
            f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_sltu:    return (a < b) ? 32'd1 : 32'd0;
            f3_xor:     return a ^ b;
            f3_srl_sra: return ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic check_wb(input string name, input wb_t expected);
        checks++;
        if (wb_o !== expected) begin
            errors++;
            $display(
                "FAILED %s: expected valid=%0b rd=%0d data=%h, actual valid=%0b rd=%0d data=%h",
                name, expected.valid, expected.rd, expected.data,
                wb_o.valid, wb_o.rd, wb_o.data);
        end
    endtask

    task automatic check_count(input string name, input instret_t expected);
        checks++;
        if (instret_o !== expected) begin
            errors++;
            $display("FAILED %s: expected instret=%0d, actual instret=%0d",
                     name, expected, instret_o);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // issue one word then check its writeback or illegal pulse against the model
    task automatic run_instr(input string name, input instr_t ins, input logic legal);
        wb_t exp;
        int  waited;
        exp.valid     = legal;
        exp.rd        = ins[11:7];
        exp.data      = predict(ins);
        instr_i       = ins;
        instr_valid_i = 1'b1;
        waited        = 0;
        do begin
            @(posedge clk);
            #1;
            instr_valid_i = 1'b0;  // one-cycle strobe
            waited++;
        end while (!(wb_o.valid || illegal_o) && waited < resp_timeout);
        if (!(wb_o.valid || illegal_o)) begin
            errors++;
            $display("%s: no writeback or illegal pulse within %0d cycles", name, resp_timeout);
        end else if (waited != 1) begin
            errors++;
            $display("%s: response came %0d cycles after issue instead of 1", name, waited);
        end
        if (legal) begin
            check_wb(name, exp);
            if (exp.rd != 0) begin
                model[exp.rd] = exp.data;
            end
            exp_count++;
        end else begin
            check_flag({name, " valid"}, 1'b0, wb_o.valid);
        end
        check_flag({name, " illegal"}, !legal, illegal_o);
        check_count(name, exp_count);
    endtask

    task automatic imm_ops_test();
        run_instr("addi neg", imm_word(12'hffb, 0, f3_add_sub, 1), 1'b1);    // x1 = -5
        run_instr("addi min", imm_word(12'h800, 1, f3_add_sub, 2), 1'b1);    // -5 - 2048
        run_instr("slti", imm_word(12'hffc, 1, f3_slt, 3), 1'b1);            // -5 < -4
        run_instr("sltiu", imm_word(12'h001, 1, f3_sltu, 4), 1'b1);
        run_instr("sltiu max", imm_word(12'hfff, 0, f3_sltu, 5), 1'b1);      // 0 < 0xffffffff
        run_instr("xori", imm_word(12'h555, 1, f3_xor, 6), 1'b1);
        run_instr("ori", imm_word(12'h0f0, 1, f3_or, 7), 1'b1);
        run_instr("andi", imm_word(12'h7ff, 1, f3_and, 8), 1'b1);
        run_instr("slli", imm_word({f7_base, 5'd7}, 1, f3_sll, 9), 1'b1);
        run_instr("srli", imm_word({f7_base, 5'd4}, 1, f3_srl_sra, 10), 1'b1);
        run_instr("srai", imm_word({f7_alt, 5'd4}, 1, f3_srl_sra, 11), 1'b1);
        run_instr("lui top", lui_word(20'h80000, 12), 1'b1);
        run_instr("lui", lui_word(20'h12345, 13), 1'b1);
    endtask

    task automatic reg_ops_test();
        run_instr("load x14", lui_word(20'h80000, 14), 1'b1);               // int min
        run_instr("load x15", imm_word(12'h001, 0, f3_add_sub, 15), 1'b1);
        run_instr("load x16", imm_word(12'hfff, 0, f3_add_sub, 16), 1'b1);  // -1
        run_instr("load x17", imm_word(12'h7ff, 0, f3_add_sub, 17), 1'b1);
        run_instr("load x18", imm_word(12'h01f, 0, f3_add_sub, 18), 1'b1);  // shift 31
        run_instr("add", op_word(f7_base, 16, 14, f3_add_sub, 19), 1'b1);
        run_instr("sub", op_word(f7_alt, 16, 15, f3_add_sub, 19), 1'b1);
        run_instr("sll", op_word(f7_base, 18, 15, f3_sll, 19), 1'b1);
        run_instr("slt min", op_word(f7_base, 15, 14, f3_slt, 19), 1'b1);
        run_instr("sltu min", op_word(f7_base, 15, 14, f3_sltu, 19), 1'b1);
        run_instr("slt neg", op_word(f7_base, 16, 15, f3_slt, 19), 1'b1);
        run_instr("sltu neg", op_word(f7_base, 16, 15, f3_sltu, 19), 1'b1);
        run_instr("xor", op_word(f7_base, 16, 14, f3_xor, 19), 1'b1);
        run_instr("srl", op_word(f7_base, 18, 14, f3_srl_sra, 19), 1'b1);
        run_instr("sra", op_word(f7_alt, 18, 14, f3_srl_sra, 19), 1'b1);
        run_instr("or", op_word(f7_base, 15, 14, f3_or, 19), 1'b1);
        run_instr("and", op_word(f7_base, 17, 16, f3_and, 19), 1'b1);
    endtask

    // each word reads the rd of the one before with no idle cycles
    task automatic forwarding_test();
        run_instr("fwd addi", imm_word(12'h003, 0, f3_add_sub, 20), 1'b1);
        run_instr("fwd add", op_word(f7_base, 20, 20, f3_add_sub, 20), 1'b1);
        run_instr("fwd slli", imm_word({f7_base, 5'd4}, 20, f3_sll, 21), 1'b1);
        run_instr("fwd sub", op_word(f7_alt, 16, 21, f3_add_sub, 22), 1'b1);
        run_instr("fwd and", op_word(f7_base, 21, 22, f3_and, 23), 1'b1);
        run_instr("fwd srai", imm_word({f7_alt, 5'd2}, 23, f3_srl_sra, 23), 1'b1);
        run_instr("fwd sltu", op_word(f7_base, 23, 0, f3_sltu, 24), 1'b1);
    endtask

    task automatic x0_test();
        run_instr("x0 addi", imm_word(12'h04d, 15, f3_add_sub, 0), 1'b1);  // retires with rd 0
        run_instr("x0 read", op_word(f7_base, 0, 0, f3_add_sub, 25), 1'b1);
        run_instr("x0 ori", imm_word(12'h123, 0, f3_or, 26), 1'b1);
        run_instr("x0 lui", lui_word(20'hfffff, 0), 1'b1);
        run_instr("x0 sub", op_word(f7_alt, 15, 0, f3_add_sub, 27), 1'b1);
    endtask

    task automatic illegal_test();
        run_instr("bad opcode", 32'h0000_00ff, 1'b0);                         // rd x1
        run_instr("bad funct7", op_word(7'b0000001, 2, 1, f3_add_sub, 1), 1'b0);
        run_instr("alt xor", op_word(f7_alt, 2, 1, f3_xor, 1), 1'b0);
        run_instr("alt slli", imm_word({f7_alt, 5'd3}, 1, f3_sll, 1), 1'b0);
        run_instr("x1 kept", imm_word(12'h000, 1, f3_add_sub, 28), 1'b1);
    endtask

    task automatic random_test();
        instr_t     ins;
        int         kind;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        for (int i = 0; i < random_count; i++) begin
            kind = $unsigned($random(seed)) % 3;
            f3   = 3'($random(seed));
            alt  = 1'($random(seed));
            rd   = 5'($random(seed));
            rs1  = 5'($random(seed));
            rs2  = 5'($random(seed));  // also the shamt
            case (kind)
                0: begin
                    f7  = (alt && (f3 == f3_add_sub || f3 == f3_srl_sra)) ? f7_alt : f7_base;
                    ins = op_word(f7, rs2, rs1, f3, rd);
                end
                1: begin
                    f7 = (alt && f3 == f3_srl_sra) ? f7_alt : f7_base;
                    if (f3 == f3_sll || f3 == f3_srl_sra) begin
                        ins = imm_word({f7, rs2}, rs1, f3, rd);
                    end else begin
                        ins = imm_word(12'($random(seed)), rs1, f3, rd);
                    end
                end
                default: ins = lui_word(20'($random(seed)), rd);
            endcase
            run_instr($sformatf("random %0d", i), ins, 1'b1);
        end
    endtask

    initial begin
        seed          = 81;
        errors        = 0;
        checks        = 0;
        exp_count     = '0;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        foreach (model[i]) begin
            model[i] = '0;  // matches regfile reset
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check_flag("reset wb valid", 1'b0, wb_o.valid);
        check_flag("reset illegal", 1'b0, illegal_o);
        check_count("reset", '0);
        imm_ops_test();
        reg_ops_test();
        forwarding_test();
        x0_test();
        illegal_test();
        random_test();
        check_count("final instret", exp_count);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // guard against a stuck run
    initial begin
        repeat (watchdog_limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== rv_exec_top.f ====
rtl/rv_isa_pkg.sv
rtl/rv_exec_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_wb_stage.sv
rtl/rv_exec_top.sv
dv/rv_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= rv_exec_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail unless the pass line is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
